// ==== csrChecker.sv ====
`timescale 1ns/1ps

module csrChecker (
    input logic             Clk,
    input logic             rstN,
    input csrPkg::csrWbT    wb,
    input csrPkg::cacheCmdT icacheCmd,
    input csrPkg::cacheCmdT dcacheCmd,
    input csrPkg::mmuCmdT   mmuCmd
);

    // One expected commit result
    typedef struct packed {
        csrPkg::csrWbT    wb;
        csrPkg::cacheCmdT ic;
        csrPkg::cacheCmdT dc;
        csrPkg::mmuCmdT   mmu;
    } expT;

    expT expQ [$];
    int  idQ [$];
    int  nextId    = 1;
    int  passCount = 0;
    int  failCount = 0;

    // Called by the testbench top, in issue order
    task automatic expectOutputs(input csrPkg::csrWbT w, input csrPkg::cacheCmdT ic,
                                 input csrPkg::cacheCmdT dc, input csrPkg::mmuCmdT m);
        expT e;
        e.wb  = w;
        e.ic  = ic;
        e.dc  = dc;
        e.mmu = m;
        expQ.push_back(e);
        idQ.push_back(nextId);
        nextId++;
    endtask

    function automatic int pending();
        return expQ.size();
    endfunction

    function automatic bit fieldOk(input string name, input logic [31:0] expV,
                                   input logic [31:0] actV);
        if (actV !== expV) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expV, actV);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // Outputs are registered on posedge, sample mid-cycle
    always @(negedge Clk) begin
        expT e;
        int  id;
        bit  ok;
        if (rstN && (wb.valid || icacheCmd.valid || dcacheCmd.valid ||
                     mmuCmd.iValid || mmuCmd.dValid)) begin
            if (expQ.size() == 0) begin
                $display("unexpected output pulse at %0t with no result pending", $time);
                failCount++;
            end else begin
                e  = expQ.pop_front();
                id = idQ.pop_front();
                ok = 1'b1;
                ok = ok & fieldOk("wb.valid", 32'(e.wb.valid), 32'(wb.valid));
                ok = ok & fieldOk("icacheCmd.valid", 32'(e.ic.valid), 32'(icacheCmd.valid));
                ok = ok & fieldOk("dcacheCmd.valid", 32'(e.dc.valid), 32'(dcacheCmd.valid));
                ok = ok & fieldOk("mmuCmd.iValid", 32'(e.mmu.iValid), 32'(mmuCmd.iValid));
                ok = ok & fieldOk("mmuCmd.dValid", 32'(e.mmu.dValid), 32'(mmuCmd.dValid));
                // Payloads only matter under their valid
                if (e.wb.valid) begin
                    ok = ok & fieldOk("wb.destTag", 32'(e.wb.destTag), 32'(wb.destTag));
                    ok = ok & fieldOk("wb.data", e.wb.data, wb.data);
                end
                if (e.ic.valid) begin
                    ok = ok & fieldOk("icacheCmd.op", 32'(e.ic.op), 32'(icacheCmd.op));
                    ok = ok & fieldOk("icacheCmd.va", e.ic.va, icacheCmd.va);
                end
                if (e.dc.valid) begin
                    ok = ok & fieldOk("dcacheCmd.op", 32'(e.dc.op), 32'(dcacheCmd.op));
                    ok = ok & fieldOk("dcacheCmd.va", e.dc.va, dcacheCmd.va);
                end
                if (e.mmu.iValid || e.mmu.dValid) begin
                    ok = ok & fieldOk("mmuCmd.va", e.mmu.va, mmuCmd.va);
                end
                if (ok) begin
                    passCount++;
                    $display("check %0d ok at %0t", id, $time);
                end else begin
                    failCount++;
                    $display("check %0d wrong at %0t", id, $time);
                end
            end
        end
    end

    // Anything still queued never showed up
    task automatic finishCheck();
        foreach (idQ[i]) begin
            $display("check %0d: expected output pulse never appeared", idQ[i]);
        end
        failCount += idQ.size();
        idQ.delete();
        expQ.delete();
        $display("checks done: %0d ok, %0d wrong", passCount, failCount);
    endtask

endmodule

// ==== csrCommitResult.sv ====
`timescale 1ns/1ps

module csrCommitResult (
    input  logic                         Clk,
    input  logic                         rstN,
    input  csrPkg::csrEntryT             commitEntry,
    input  logic [csrPkg::DataWidth-1:0] oldData,
    output csrPkg::csrWbT                wb,
    output csrPkg::cacheCmdT             icacheCmd,
    output csrPkg::cacheCmdT             dcacheCmd,
    output csrPkg::mmuCmdT               mmuCmd
);

    logic                            isCsrOp;
    logic                            isCacop;
    logic                            toIcache;
    logic                            toDcache;
    logic                            mmuNotice;
    logic                            wbValid;
    logic                            icValid;
    logic                            dcValid;
    logic                            mmuIValid;
    logic                            mmuDValid;
    logic [csrPkg::TagWidth-1:0]     wbTag;
    logic [csrPkg::DataWidth-1:0]    wbData;
    logic [csrPkg::CacheOpWidth-1:0] cmdOp;
    logic [csrPkg::DataWidth-1:0]    cmdVa;

    assign isCacop   = commitEntry.valid && (commitEntry.op == csrPkg::OpCacop);
    assign isCsrOp   = commitEntry.valid && (commitEntry.op != csrPkg::OpCacop);
    assign toIcache  = isCacop && (commitEntry.cacheTarget == csrPkg::CacheTgtIcache);
    assign toDcache  = isCacop && (commitEntry.cacheTarget == csrPkg::CacheTgtDcache);
    // MMU hears about op 2 on either cache
    assign mmuNotice = commitEntry.cacheOp == csrPkg::CacopMmuOp;

    // Valids, one-cycle pulses after commit
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wbValid   <= 1'b0;
            icValid   <= 1'b0;
            dcValid   <= 1'b0;
            mmuIValid <= 1'b0;
            mmuDValid <= 1'b0;
        end else begin
            wbValid   <= isCsrOp;
            icValid   <= toIcache;
            dcValid   <= toDcache;
            mmuIValid <= toIcache && mmuNotice;
            mmuDValid <= toDcache && mmuNotice;
        end
    end

    // Payloads
    always_ff @(posedge Clk) begin
        if (isCsrOp) begin
            wbTag  <= commitEntry.destTag;
            wbData <= oldData;
        end
        if (isCacop) begin
            cmdOp <= commitEntry.cacheOp;
            cmdVa <= commitEntry.va;
        end
    end

    assign wb.valid        = wbValid;
    assign wb.destTag      = wbTag;
    assign wb.data         = wbData;
    // Both caches share op and va
    assign icacheCmd.valid = icValid;
    assign icacheCmd.op    = cmdOp;
    assign icacheCmd.va    = cmdVa;
    assign dcacheCmd.valid = dcValid;
    assign dcacheCmd.op    = cmdOp;
    assign dcacheCmd.va    = cmdVa;
    assign mmuCmd.iValid   = mmuIValid;
    assign mmuCmd.dValid   = mmuDValid;
    assign mmuCmd.va       = cmdVa;

endmodule

// ==== csrIssueDecode.sv ====
`timescale 1ns/1ps

module csrIssueDecode (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             issueReq,
    input  csrPkg::csrIssueT issue,
    input  logic             queueFull,
    output logic             issueAck,
    output csrPkg::csrEntryT pushEntry
);

    logic             capture;
    logic             opKnown;
    csrPkg::csrEntryT decoded;

    // Fresh request, previous ack already dropped, room in queue
    assign capture = issueReq && !issueAck && !queueFull;

    // Four-phase ack
    // Rises on capture, falls once the producer releases req
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            issueAck <= 1'b0;
        end else if (capture) begin
            issueAck <= 1'b1;
        end else if (!issueReq) begin
            issueAck <= 1'b0;
        end
    end

    // Micro-op to queue entry
    always_comb begin
        decoded         = '0;
        opKnown         = 1'b1;
        decoded.csrNum  = issue.csrNum;
        decoded.destTag = issue.destTag;
        case (issue.microOp)
            csrPkg::MicCsrrd: begin
                // Zero mask, merge keeps the old value
                decoded.op = csrPkg::OpCsrrd;
            end
            csrPkg::MicCsrwr: begin
                decoded.op    = csrPkg::OpCsrwr;
                decoded.wdata = issue.rj;
                decoded.wmask = '1;
            end
            csrPkg::MicCsrxchg: begin
                // rk carries the bit mask
                decoded.op    = csrPkg::OpCsrxchg;
                decoded.wdata = issue.rj;
                decoded.wmask = issue.rk;
            end
            csrPkg::MicCacop: begin
                decoded.op          = csrPkg::OpCacop;
                decoded.va          = issue.rj + issue.rk;
                decoded.cacheTarget = issue.csrNum[2:0];
                decoded.cacheOp     = issue.csrNum[4:3];
            end
            default: begin
                opKnown = 1'b0;
            end
        endcase
    end

    // Unknown codes get acked but never reach the queue
    always_comb begin
        pushEntry       = decoded;
        pushEntry.valid = capture && opKnown;
    end

    // Ack only rises after a cycle in which the queue had room
    assert property (@(posedge Clk) disable iff (!rstN)
        $rose(issueAck) |-> !$past(queueFull))
        else $error("issueAck rose while queue full");

endmodule

// ==== csrOpQueue.sv ====
`timescale 1ns/1ps

module csrOpQueue (
    input  logic             Clk,
    input  logic             rstN,
    input  csrPkg::csrEntryT pushEntry,
    input  logic             commit,
    output logic             queueFull,
    output csrPkg::csrEntryT commitEntry
);

    csrPkg::csrEntryT                 entryMem [csrPkg::QueueDepth];
    logic [csrPkg::QueuePtrWidth-1:0] frontPtr;
    logic [csrPkg::QueuePtrWidth-1:0] endPtr;
    logic [csrPkg::QueuePtrWidth:0]   count;
    logic                             queueEmpty;
    logic                             push;
    logic                             pop;

    assign queueFull  = count == (csrPkg::QueuePtrWidth + 1)'(csrPkg::QueueDepth);
    assign queueEmpty = count == '0;
    assign push       = pushEntry.valid && !queueFull;
    // Commit on an empty queue is dropped
    assign pop        = commit && !queueEmpty;

    // Entry storage
    always_ff @(posedge Clk) begin
        if (push) begin
            entryMem[endPtr] <= pushEntry;
        end
    end

    // Front is the oldest entry, end is the next free slot
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            frontPtr <= '0;
            endPtr   <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                endPtr <= endPtr + csrPkg::QueuePtrWidth'(1);
            end
            if (pop) begin
                frontPtr <= frontPtr + csrPkg::QueuePtrWidth'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head shown for the commit cycle only
    always_comb begin
        commitEntry       = entryMem[frontPtr];
        commitEntry.valid = pop;
    end

    // Issue side must hold back while full
    assert property (@(posedge Clk) disable iff (!rstN)
        pushEntry.valid |-> !queueFull)
        else $error("push into full CSR queue");

    assert property (@(posedge Clk) disable iff (!rstN)
        count <= csrPkg::QueueDepth)
        else $error("CSR queue count overflow");

endmodule

// ==== csrPkg.sv ====
package csrPkg;

    // Datapath widths
    localparam int DataWidth     = 32;
    localparam int CsrAddrWidth  = 14;
    localparam int TagWidth      = 8;
    localparam int MicOpWidth    = 8;
    localparam int CacheTgtWidth = 3;
    localparam int CacheOpWidth  = 2;

    // Op queue sizing, pointer wraps naturally at the depth
    localparam int QueueDepth    = 16;
    localparam int QueuePtrWidth = 4;

    // Issued micro-op codes
    localparam logic [MicOpWidth-1:0] MicCsrrd   = 8'h01;
    localparam logic [MicOpWidth-1:0] MicCsrwr   = 8'h02;
    localparam logic [MicOpWidth-1:0] MicCsrxchg = 8'h03;
    localparam logic [MicOpWidth-1:0] MicCacop   = 8'h04;

    // CSR numbers from the architecture map
    localparam logic [CsrAddrWidth-1:0] CsrCrmd   = 14'h000;
    localparam logic [CsrAddrWidth-1:0] CsrPrmd   = 14'h001;
    localparam logic [CsrAddrWidth-1:0] CsrEcfg   = 14'h004;
    localparam logic [CsrAddrWidth-1:0] CsrEstat  = 14'h005;
    localparam logic [CsrAddrWidth-1:0] CsrEra    = 14'h006;
    localparam logic [CsrAddrWidth-1:0] CsrBadv   = 14'h007;
    localparam logic [CsrAddrWidth-1:0] CsrEentry = 14'h00c;
    localparam logic [CsrAddrWidth-1:0] CsrSave0  = 14'h030;
    localparam logic [CsrAddrWidth-1:0] CsrSave1  = 14'h031;
    localparam logic [CsrAddrWidth-1:0] CsrSave2  = 14'h032;
    localparam logic [CsrAddrWidth-1:0] CsrSave3  = 14'h033;
    localparam logic [CsrAddrWidth-1:0] CsrTid    = 14'h040;
    localparam logic [CsrAddrWidth-1:0] CsrDmw0   = 14'h180;
    localparam logic [CsrAddrWidth-1:0] CsrDmw1   = 14'h181;

    // Storage slot order, CRMD sits in slot 0
    localparam int CsrCount = 14;
    localparam int CrmdIdx  = 0;
    localparam logic [CsrAddrWidth-1:0] CsrMap [CsrCount] = '{
        CsrCrmd, CsrPrmd, CsrEcfg, CsrEstat, CsrEra, CsrBadv, CsrEentry,
        CsrSave0, CsrSave1, CsrSave2, CsrSave3, CsrTid, CsrDmw0, CsrDmw1
    };

    // Only CRMD has a nonzero reset value
    localparam logic [DataWidth-1:0] CrmdReset = 32'h8;

    // Cacop target and op codes
    localparam logic [CacheTgtWidth-1:0] CacheTgtIcache = 3'd0;
    localparam logic [CacheTgtWidth-1:0] CacheTgtDcache = 3'd1;
    localparam logic [CacheOpWidth-1:0]  CacopMmuOp     = 2'd2;

    typedef enum logic [1:0] {
        OpCsrrd,
        OpCsrwr,
        OpCsrxchg,
        OpCacop
    } csrOpT;

    // Micro-op as it arrives from issue
    typedef struct packed {
        logic [MicOpWidth-1:0]   microOp;
        logic [DataWidth-1:0]    rj;
        logic [DataWidth-1:0]    rk;
        logic [CsrAddrWidth-1:0] csrNum;
        logic [TagWidth-1:0]     destTag;
    } csrIssueT;

    // Decoded entry held until commit
    typedef struct packed {
        logic                     valid;
        csrOpT                    op;
        logic [CsrAddrWidth-1:0]  csrNum;
        logic [DataWidth-1:0]     wdata;
        logic [DataWidth-1:0]     wmask;
        logic [TagWidth-1:0]      destTag;
        logic [DataWidth-1:0]     va;
        logic [CacheTgtWidth-1:0] cacheTarget;
        logic [CacheOpWidth-1:0]  cacheOp;
    } csrEntryT;

    typedef struct packed {
        logic                 valid;
        logic [TagWidth-1:0]  destTag;
        logic [DataWidth-1:0] data;
    } csrWbT;

    typedef struct packed {
        logic                    valid;
        logic [CacheOpWidth-1:0] op;
        logic [DataWidth-1:0]    va;
    } cacheCmdT;

    typedef struct packed {
        logic                 iValid;
        logic                 dValid;
        logic [DataWidth-1:0] va;
    } mmuCmdT;

endpackage

// ==== csrRegFile.sv ====
`timescale 1ns/1ps

module csrRegFile (
    input  logic                         Clk,
    input  logic                         rstN,
    input  csrPkg::csrEntryT             commitEntry,
    output logic [csrPkg::DataWidth-1:0] oldData
);

    logic [csrPkg::DataWidth-1:0] csrStore [csrPkg::CsrCount];
    logic [csrPkg::CsrCount-1:0]  csrSel;
    logic [csrPkg::CsrCount-1:0]  csrWen;
    logic                         writeOp;
    logic [csrPkg::DataWidth-1:0] mergeData;

    // Address decode against the kept map
    // Unmapped numbers leave every select low
    always_comb begin
        for (int i = 0; i < csrPkg::CsrCount; i++) begin
            csrSel[i] = commitEntry.csrNum == csrPkg::CsrMap[i];
        end
    end

    // Old value, zero when nothing matches
    always_comb begin
        oldData = '0;
        for (int i = 0; i < csrPkg::CsrCount; i++) begin
            if (csrSel[i]) begin
                oldData = csrStore[i];
            end
        end
    end

    // Every committed CSR op writes back the merge
    // csrrd has an empty mask so the value stays put
    assign writeOp   = commitEntry.valid && (commitEntry.op != csrPkg::OpCacop);
    assign csrWen    = csrSel & {csrPkg::CsrCount{writeOp}};

    // Mask set picks new bits, mask clear keeps old ones
    assign mergeData = (oldData & ~commitEntry.wmask) |
                       (commitEntry.wdata & commitEntry.wmask);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < csrPkg::CsrCount; i++) begin
                csrStore[i] <= (i == csrPkg::CrmdIdx) ? csrPkg::CrmdReset : '0;
            end
        end else begin
            for (int i = 0; i < csrPkg::CsrCount; i++) begin
                if (csrWen[i]) begin
                    csrStore[i] <= mergeData;
                end
            end
        end
    end

    // One register per commit at most
    assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0(csrWen))
        else $error("multiple CSR write enables");

endmodule

// ==== csrUnit.f ====
csrPkg.sv
csrIssueDecode.sv
csrOpQueue.sv
csrRegFile.sv
csrCommitResult.sv
csrUnit.sv
csrChecker.sv
tbCsrUnit.sv

// ==== csrUnit.sv ====
`timescale 1ns/1ps

module csrUnit (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             issueReq,
    input  csrPkg::csrIssueT issue,
    output logic             issueAck,
    input  logic             commit,
    output csrPkg::csrWbT    wb,
    output csrPkg::cacheCmdT icacheCmd,
    output csrPkg::cacheCmdT dcacheCmd,
    output csrPkg::mmuCmdT   mmuCmd
);

    csrPkg::csrEntryT             pushEntry;
    csrPkg::csrEntryT             commitEntry;
    logic                         queueFull;
    logic [csrPkg::DataWidth-1:0] oldData;

    // Issue handshake and decode
    csrIssueDecode u_issueDecode (
        .Clk       (Clk),
        .rstN      (rstN),
        .issueReq  (issueReq),
        .issue     (issue),
        .queueFull (queueFull),
        .issueAck  (issueAck),
        .pushEntry (pushEntry)
    );

    // In-order hold until ROB commit
    csrOpQueue u_opQueue (
        .Clk         (Clk),
        .rstN        (rstN),
        .pushEntry   (pushEntry),
        .commit      (commit),
        .queueFull   (queueFull),
        .commitEntry (commitEntry)
    );

    // CSR storage, old value back the same cycle
    csrRegFile u_regFile (
        .Clk         (Clk),
        .rstN        (rstN),
        .commitEntry (commitEntry),
        .oldData     (oldData)
    );

    csrCommitResult u_commitResult (
        .Clk         (Clk),
        .rstN        (rstN),
        .commitEntry (commitEntry),
        .oldData     (oldData),
        .wb          (wb),
        .icacheCmd   (icacheCmd),
        .dcacheCmd   (dcacheCmd),
        .mmuCmd      (mmuCmd)
    );

endmodule

// ==== tbCsrUnit.sv ====
`timescale 1ns/1ps

module tbCsrUnit;

    localparam int ClkPeriod = 40;
    localparam int AckLimit  = 20;
    localparam int BlockWait = 6;

    // Operands for the write, exchange and cacop rows
    localparam logic [31:0] Save1Val = 32'hdead_beef;
    localparam logic [31:0] EraA     = 32'hcafe_1234;
    localparam logic [31:0] EraB     = 32'h5a5a_a5a5;
    localparam logic [31:0] EraM     = 32'h00ff_f00f;

    // One stimulus row with its expected result
    typedef struct packed {
        csrPkg::csrIssueT op;
        logic [4:0]       commits;
        logic             blocked;
        csrPkg::csrWbT    expWb;
        csrPkg::cacheCmdT expIc;
        csrPkg::cacheCmdT expDc;
        csrPkg::mmuCmdT   mmuExp;
    } rowT;

    logic             Clk;
    logic             rstN;
    logic             issueReq;
    csrPkg::csrIssueT issue;
    logic             issueAck;
    logic             commit;
    csrPkg::csrWbT    wb;
    csrPkg::cacheCmdT icacheCmd;
    csrPkg::cacheCmdT dcacheCmd;
    csrPkg::mmuCmdT   mmuCmd;
    rowT              stimTable [$];
    int               drvErrors = 0;

    csrUnit u_dut (
        .Clk       (Clk),
        .rstN      (rstN),
        .issueReq  (issueReq),
        .issue     (issue),
        .issueAck  (issueAck),
        .commit    (commit),
        .wb        (wb),
        .icacheCmd (icacheCmd),
        .dcacheCmd (dcacheCmd),
        .mmuCmd    (mmuCmd)
    );

    csrChecker u_checker (
        .Clk       (Clk),
        .rstN      (rstN),
        .wb        (wb),
        .icacheCmd (icacheCmd),
        .dcacheCmd (dcacheCmd),
        .mmuCmd    (mmuCmd)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    // CSR op row, expects a writeback to its own tag
    function automatic rowT csrRow(input logic [7:0] micro, input logic [13:0] num,
                                   input logic [31:0] rj, input logic [31:0] rk,
                                   input logic [7:0] tag, input logic [4:0] commits,
                                   input logic [31:0] expData);
        rowT r;
        r                = '0;
        r.op.microOp     = micro;
        r.op.rj          = rj;
        r.op.rk          = rk;
        r.op.csrNum      = num;
        r.op.destTag     = tag;
        r.commits        = commits;
        r.expWb.valid    = 1'b1;
        r.expWb.destTag  = tag;
        r.expWb.data     = expData;
        return r;
    endfunction

    // Cacop row, routed by target, MMU told on op 2
    function automatic rowT cacopRow(input logic [2:0] target, input logic [1:0] cop,
                                     input logic [31:0] rj, input logic [31:0] rk,
                                     input logic [7:0] tag);
        rowT         r;
        logic [31:0] va;
        va           = rj + rk;
        r            = '0;
        r.op.microOp = csrPkg::MicCacop;
        r.op.rj      = rj;
        r.op.rk      = rk;
        r.op.csrNum  = {9'b0, cop, target};
        r.op.destTag = tag;
        r.commits    = 5'd1;
        r.mmuExp.va  = va;
        if (target == 3'd0) begin
            r.expIc          = {1'b1, cop, va};
            r.mmuExp.iValid  = (cop == 2'd2);
        end else begin
            r.expDc          = {1'b1, cop, va};
            r.mmuExp.dValid  = (cop == 2'd2);
        end
        return r;
    endfunction

    task automatic fillTable();
        rowT r;
        stimTable.push_back(csrRow(csrPkg::MicCsrrd, csrPkg::CsrCrmd, 0, 0, 8'h01, 1, 32'h8));
        stimTable.push_back(csrRow(csrPkg::MicCsrrd, csrPkg::CsrSave0, 0, 0, 8'h02, 1, 0));
        stimTable.push_back(csrRow(csrPkg::MicCsrwr, csrPkg::CsrSave1, Save1Val, 0, 8'h03, 1, 0));
        stimTable.push_back(csrRow(csrPkg::MicCsrrd, csrPkg::CsrSave1, 0, 0, 8'h04, 1, Save1Val));
        stimTable.push_back(csrRow(csrPkg::MicCsrwr, csrPkg::CsrEra, EraA, 0, 8'h05, 1, 0));
        stimTable.push_back(csrRow(csrPkg::MicCsrxchg, csrPkg::CsrEra, EraB, EraM, 8'h06, 1, EraA));
        stimTable.push_back(csrRow(csrPkg::MicCsrrd, csrPkg::CsrEra, 0, 0, 8'h07, 1,
                                   (EraA & ~EraM) | (EraB & EraM)));
        // Unmapped address reads and writes nothing
        stimTable.push_back(csrRow(csrPkg::MicCsrwr, 14'h3ff, 32'h1234_5678, 0, 8'h08, 1, 0));
        stimTable.push_back(csrRow(csrPkg::MicCsrrd, 14'h3ff, 0, 0, 8'h09, 1, 0));
        stimTable.push_back(cacopRow(3'd0, 2'd1, 32'h1000_0000, 32'h0000_0040, 8'h0a));
        stimTable.push_back(cacopRow(3'd1, 2'd2, 32'h8000_1ff0, 32'h0000_0020, 8'h0b));
        // Fill the queue with no commits
        for (int i = 0; i < 16; i++) begin
            stimTable.push_back(csrRow(csrPkg::MicCsrrd,
                                       i[0] ? csrPkg::CsrCrmd : csrPkg::CsrSave1, 0, 0,
                                       8'(8'h20 + i), 0, i[0] ? 32'h8 : Save1Val));
        end
        // 17th waits for a commit, then drains everything
        r         = csrRow(csrPkg::MicCsrrd, csrPkg::CsrSave0, 0, 0, 8'h30, 16, 0);
        r.blocked = 1'b1;
        stimTable.push_back(r);
    endtask

    // Back-to-back commit pulses from the current falling edge
    task automatic sendCommits(input int n);
        repeat (n) begin
            commit = 1'b1;
            @(negedge Clk);
        end
        commit = 1'b0;
    endtask

    task automatic waitAck(input logic level);
        int n;
        n = 0;
        while (issueAck !== level && n < AckLimit) begin
            @(negedge Clk);
            n++;
        end
        if (issueAck !== level) begin
            $display("issueAck did not go to %0b within %0d cycles at %0t", level, AckLimit,
                     $time);
            drvErrors++;
        end
    endtask

    // Full four-phase issue of one row, then its commits
    task automatic issueOp(input rowT r);
        if (r.expWb.valid || r.expIc.valid || r.expDc.valid) begin
            u_checker.expectOutputs(r.expWb, r.expIc, r.expDc, r.mmuExp);
        end
        @(negedge Clk);
        issue    = r.op;
        issueReq = 1'b1;
        if (r.blocked) begin
            repeat (BlockWait) begin
                @(negedge Clk);
                if (issueAck) begin
                    $display("issueAck rose at %0t while the queue was full", $time);
                    drvErrors++;
                end
            end
            sendCommits(1);
        end
        waitAck(1'b1);
        issueReq = 1'b0;
        waitAck(1'b0);
        sendCommits(r.commits);
    endtask

    initial begin
        int n;
        rstN     = 1'b0;
        issueReq = 1'b0;
        issue    = '0;
        commit   = 1'b0;
        fillTable();
        repeat (8) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        foreach (stimTable[i]) begin
            issueOp(stimTable[i]);
        end
        // Let the last results drain, then look for stray pulses
        n = 0;
        while (u_checker.pending() > 0 && n < AckLimit) begin
            @(negedge Clk);
            n++;
        end
        repeat (2) @(negedge Clk);
        u_checker.finishCheck();
        if (u_checker.failCount == 0 && drvErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, 40 cycles per row plus slack
    initial begin
        #1;
        #((stimTable.size() * 40 + 200) * ClkPeriod);
        $display("watchdog expired at %0t before the table finished", $time);
        $display("test failed");
        $finish;
    end

endmodule
